//--- rvv_pkg.sv
// rvv backend shared widths, vector csr and retire entry types
package rvv_pkg;

  localparam int VLEN      = 64;         // vector register width in bits
  localparam int VLENB     = VLEN / 8;   // same in bytes
  localparam int XLEN      = 32;
  localparam int REG_IDX_W = 5;          // 32 registers per file

  typedef struct packed {
    logic [7:0] vstart;
    logic [7:0] vl;
  } vector_csr_t;

  ////////////////////
  // result word
  ////////////////////
  // one word, read as a full vector or as a scalar in its low bits
  typedef union packed {
    logic [VLEN-1:0] vec;
    struct packed {
      logic [VLEN-XLEN-1:0] pad;
      logic [XLEN-1:0]      val;
    } scalar;
  } rt_data_u;

  ////////////////////
  // rob entry
  ////////////////////
  typedef struct packed {
    logic                 w_valid;      // uop writes a register
    logic                 w_type;       // 0 vrf, 1 xrf
    logic [REG_IDX_W-1:0] w_index;
    rt_data_u             w_data;
    logic [VLENB-1:0]     vd_strobe;    // body bytes enabled
    logic                 ignore_vta;
    logic                 ignore_vma;
    logic                 trap_flag;
    vector_csr_t          vector_csr;
    logic                 vxsat;
  } rob_entry_t;

endpackage

//--- rvv_ifs.sv
// internal buses of the retire stage: rob offer, xrf requests and wishbone
interface rob_rt_if #(parameter int NUM_RT_UOP = 4);
  import rvv_pkg::*;

  logic       [NUM_RT_UOP-1:0] valid;
  rob_entry_t [NUM_RT_UOP-1:0] entry;   // oldest entry in lane 0
  logic       [NUM_RT_UOP-1:0] ready;

  modport rob (output valid, output entry, input ready);
  modport rt  (input valid, input entry, output ready);
endinterface

interface xrf_req_if #(parameter int NUM_RT_UOP = 4);
  import rvv_pkg::*;

  logic [NUM_RT_UOP-1:0]                valid;
  logic [NUM_RT_UOP-1:0][REG_IDX_W-1:0] index;
  logic [NUM_RT_UOP-1:0][XLEN-1:0]      data;
  logic [NUM_RT_UOP-1:0]                ready;  // pulses with the bus ack

  modport rt  (output valid, output index, output data, input ready);
  modport arb (input valid, input index, input data, output ready);
endinterface

interface wb_if;
  import rvv_pkg::*;

  logic                 cyc;
  logic                 stb;
  logic                 we;
  logic [REG_IDX_W-1:0] adr;
  logic [XLEN-1:0]      dat_w;
  logic                 ack;

  modport master (output cyc, output stb, output we, output adr, output dat_w, input ack);
  modport slave  (input cyc, input stb, input we, input adr, input dat_w, output ack);
endinterface

//--- rvv_rob.sv
// reorder buffer, in-order push and multi-lane in-order pop to retire
module rvv_rob #(
  parameter int NUM_RT_UOP = 4,
  parameter int ROB_DEPTH  = 8   // power of two, pointers wrap naturally
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                push_valid,
  input  rvv_pkg::rob_entry_t push_entry,
  output logic                push_ready,
  rob_rt_if.rob               rt
);
  import rvv_pkg::*;

  localparam int PTR_W = $clog2(ROB_DEPTH);
  localparam int CNT_W = $clog2(ROB_DEPTH + 1);
  localparam int POP_W = $clog2(NUM_RT_UOP + 1);

  rob_entry_t       mem [ROB_DEPTH];
  logic [PTR_W-1:0] head;
  logic [PTR_W-1:0] tail;
  logic [CNT_W-1:0] count;
  logic [POP_W-1:0] pop_cnt;   // lanes leaving this cycle
  logic             push_fire;

  assign push_ready = (count != CNT_W'(ROB_DEPTH));
  assign push_fire  = push_valid && push_ready;

  // offer the oldest entries, lane 0 is the head
  always_comb begin
    for (int i = 0; i < NUM_RT_UOP; i++) begin
      rt.valid[i] = (i < int'(count));
      rt.entry[i] = mem[head + PTR_W'(i)];
    end
  end

  // only the valid and ready prefix pops
  always_comb begin
    logic stop;
    stop    = 1'b0;
    pop_cnt = '0;
    for (int i = 0; i < NUM_RT_UOP; i++) begin
      if (!stop && rt.valid[i] && rt.ready[i]) begin
        pop_cnt = pop_cnt + 1'b1;
      end else begin
        stop = 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      head  <= head + PTR_W'(pop_cnt);
      if (push_fire) tail <= tail + 1'b1;
      count <= count + CNT_W'(push_fire) - CNT_W'(pop_cnt);
    end
  end

  always_ff @(posedge clk) begin
    if (push_fire) mem[tail] <= push_entry;
  end

  // pointer distance matches the count and the count stays within the depth
  a_ptr_count: assert property (@(posedge clk) disable iff (!rst_n)
    count <= CNT_W'(ROB_DEPTH) && (tail - head) == PTR_W'(count));

endmodule

//--- rvv_retire.sv
// retire unit, writes vrf and xrf results, squashes after a trap, reports vcsr and vxsat
module rvv_retire #(
  parameter int NUM_RT_UOP = 4
) (
  rob_rt_if.rt                                            rob,
  xrf_req_if.rt                                           xrf,
  output logic [NUM_RT_UOP-1:0]                           vrf_wr_valid,
  output logic [NUM_RT_UOP-1:0][rvv_pkg::REG_IDX_W-1:0]   vrf_wr_index,
  output logic [NUM_RT_UOP-1:0][rvv_pkg::VLEN-1:0]        vrf_wr_data,
  output logic [NUM_RT_UOP-1:0][rvv_pkg::VLENB-1:0]       vrf_wr_strobe,
  output logic                                            trap_valid,
  output rvv_pkg::vector_csr_t                            trap_vcsr,
  output logic                                            vxsat_valid,
  output logic                                            vxsat
);
  import rvv_pkg::*;

  logic [NUM_RT_UOP-1:0]            trap_before;  // an older valid lane traps
  logic [NUM_RT_UOP-1:0]            live;
  logic [NUM_RT_UOP-1:0][VLENB-1:0] strb_raw;     // strobe before waw masking

  ////////////////////
  // trap squash
  ////////////////////
  always_comb begin
    logic seen;
    seen = 1'b0;
    for (int i = 0; i < NUM_RT_UOP; i++) begin
      trap_before[i] = seen;   // the trapping lane itself still writes
      seen = seen | (rob.valid[i] && rob.entry[i].trap_flag);
    end
  end

  ////////////////////
  // lane decode
  ////////////////////
  always_comb begin
    for (int i = 0; i < NUM_RT_UOP; i++) begin
      live[i]         = rob.valid[i] && !trap_before[i];
      vrf_wr_valid[i] = live[i] && rob.entry[i].w_valid && !rob.entry[i].w_type;
      xrf.valid[i]    = live[i] && rob.entry[i].w_valid && rob.entry[i].w_type;
      vrf_wr_index[i] = rob.entry[i].w_index;
      vrf_wr_data[i]  = rob.entry[i].w_data.vec;
      xrf.index[i]    = rob.entry[i].w_index;
      xrf.data[i]     = rob.entry[i].w_data.scalar.val;
      // agnostic tail and mask, whole register may be overwritten
      if (rob.entry[i].ignore_vta && rob.entry[i].ignore_vma) begin
        strb_raw[i] = '1;
      end else begin
        strb_raw[i] = rob.entry[i].vd_strobe;
      end
      // vrf and squashed lanes never wait
      rob.ready[i] = xrf.valid[i] ? xrf.ready[i] : 1'b1;
    end
  end

  ////////////////////
  // waw masking
  ////////////////////
  // a byte also written by a younger lane to the same vd is dropped here
  always_comb begin
    for (int i = 0; i < NUM_RT_UOP; i++) begin
      vrf_wr_strobe[i] = strb_raw[i];
      for (int j = i + 1; j < NUM_RT_UOP; j++) begin
        if (vrf_wr_valid[j] && (rob.entry[j].w_index == rob.entry[i].w_index)) begin
          vrf_wr_strobe[i] = vrf_wr_strobe[i] & ~strb_raw[j];
        end
      end
    end
  end

  // first trapping lane owns the vcsr report
  always_comb begin
    trap_valid  = 1'b0;
    trap_vcsr   = '0;
    vxsat_valid = 1'b0;
    vxsat       = 1'b0;
    for (int i = NUM_RT_UOP - 1; i >= 0; i--) begin
      if (rob.valid[i] && rob.entry[i].trap_flag) begin
        trap_valid = 1'b1;
        trap_vcsr  = rob.entry[i].vector_csr;
      end
      vxsat_valid = vxsat_valid | (rob.valid[i] && rob.entry[i].vxsat);
      vxsat       = vxsat | (rob.valid[i] && rob.entry[i].vxsat);
    end
  end

  // nothing younger than a trapping lane reaches either register file
  always_comb begin
    for (int i = 0; i < NUM_RT_UOP; i++) begin
      if (rob.valid[i] && rob.entry[i].trap_flag) begin
        assert (((vrf_wr_valid | xrf.valid) >> (i + 1)) == '0);
      end
    end
  end

endmodule

//--- rvv_vrf.sv
// vector register file, byte-strobed write port per lane and one debug read port
module rvv_vrf #(
  parameter int NUM_RT_UOP = 4
) (
  input  logic                                          clk,
  input  logic                                          rst_n,
  input  logic [NUM_RT_UOP-1:0]                         wr_valid,
  input  logic [NUM_RT_UOP-1:0][rvv_pkg::REG_IDX_W-1:0] wr_index,
  input  logic [NUM_RT_UOP-1:0][rvv_pkg::VLEN-1:0]      wr_data,
  input  logic [NUM_RT_UOP-1:0][rvv_pkg::VLENB-1:0]     wr_strobe,
  input  logic [rvv_pkg::REG_IDX_W-1:0]                 rd_index,
  output logic [rvv_pkg::VLEN-1:0]                      rd_data
);
  import rvv_pkg::*;

  localparam int NUM_REGS = 1 << REG_IDX_W;

  logic [VLEN-1:0] regs [NUM_REGS];

  // lanes in ascending order, the younger lane lands last
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int r = 0; r < NUM_REGS; r++) regs[r] <= '0;
    end else begin
      for (int l = 0; l < NUM_RT_UOP; l++) begin
        for (int b = 0; b < VLENB; b++) begin
          if (wr_valid[l] && wr_strobe[l][b]) begin
            regs[wr_index[l]][b*8 +: 8] <= wr_data[l][b*8 +: 8];
          end
        end
      end
    end
  end

  assign rd_data = regs[rd_index];   // debug read

endmodule

//--- rvv_xrf_arbiter.sv
// fixed-priority arbiter from the xrf write lanes onto a wishbone classic master
module rvv_xrf_arbiter #(
  parameter int NUM_RT_UOP = 4
) (
  input  logic  clk,
  input  logic  rst_n,
  xrf_req_if.arb req,
  wb_if.master   wb
);

  localparam int GNT_W = (NUM_RT_UOP > 1) ? $clog2(NUM_RT_UOP) : 1;

  logic [GNT_W-1:0] pick;   // lowest requesting lane
  logic             any_req;

  always_comb begin
    pick    = '0;
    any_req = |req.valid;
    for (int i = NUM_RT_UOP - 1; i >= 0; i--) begin
      if (req.valid[i]) pick = GNT_W'(i);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb.cyc <= 1'b0;
      wb.stb <= 1'b0;
    end else if (!wb.cyc) begin
      if (any_req) begin
        wb.cyc <= 1'b1;
        wb.stb <= 1'b1;
      end
    end else if (wb.ack) begin   // close on ack
      wb.cyc <= 1'b0;
      wb.stb <= 1'b0;
    end
  end

  // address and data latched with the grant
  always_ff @(posedge clk) begin
    if (!wb.cyc && any_req) begin
      wb.adr   <= req.index[pick];
      wb.dat_w <= req.data[pick];
    end
  end

  assign wb.we = wb.cyc;   // write-only master

  // the granted uop stays the oldest xrf request and thus the lowest requesting lane
  always_comb begin
    for (int i = 0; i < NUM_RT_UOP; i++) begin
      req.ready[i] = wb.ack && (pick == GNT_W'(i));
    end
  end

  a_stb_in_cyc: assert property (@(posedge clk) disable iff (!rst_n)
    wb.stb |-> wb.cyc);

  // slave may stall, request must not move underneath it
  a_adr_hold: assert property (@(posedge clk) disable iff (!rst_n)
    wb.stb && !wb.ack |=> $stable(wb.adr) && $stable(wb.dat_w));

endmodule

//--- rvv_xrf.sv
// scalar register file behind a wishbone classic slave, with a debug read port
module rvv_xrf (
  input  logic                          clk,
  input  logic                          rst_n,
  wb_if.slave                           wb,
  input  logic [rvv_pkg::REG_IDX_W-1:0] rd_index,
  output logic [rvv_pkg::XLEN-1:0]      rd_data
);
  import rvv_pkg::*;

  localparam int NUM_REGS = 1 << REG_IDX_W;

  logic [XLEN-1:0] regs [NUM_REGS];
  logic            access;   // new request not yet acked

  assign access = wb.cyc && wb.stb && !wb.ack;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb.ack <= 1'b0;
      for (int r = 0; r < NUM_REGS; r++) regs[r] <= '0;
    end else begin
      wb.ack <= access;   // single-cycle ack per access
      if (access && wb.we) begin
        regs[wb.adr] <= wb.dat_w;
      end
    end
  end

  assign rd_data = regs[rd_index];

endmodule

//--- rvv_backend_top.sv
// retire stage top, rob feeding the retire unit, vrf, xrf arbiter and xrf
module rvv_backend_top #(
  parameter int NUM_RT_UOP = 4,
  parameter int ROB_DEPTH  = 8
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          push_valid,
  input  rvv_pkg::rob_entry_t           push_entry,
  output logic                          push_ready,
  input  logic [rvv_pkg::REG_IDX_W-1:0] vrf_rd_index,
  output logic [rvv_pkg::VLEN-1:0]      vrf_rd_data,
  input  logic [rvv_pkg::REG_IDX_W-1:0] xrf_rd_index,
  output logic [rvv_pkg::XLEN-1:0]      xrf_rd_data,
  output logic                          trap_valid,
  output rvv_pkg::vector_csr_t          trap_vcsr,
  output logic                          vxsat_valid,
  output logic                          vxsat
);
  import rvv_pkg::*;

  rob_rt_if  #(.NUM_RT_UOP(NUM_RT_UOP)) rob_rt ();
  xrf_req_if #(.NUM_RT_UOP(NUM_RT_UOP)) xrf_req ();
  wb_if                                 xrf_wb ();

  // vrf write bundle, one port per lane
  logic [NUM_RT_UOP-1:0]                vrf_wr_valid;
  logic [NUM_RT_UOP-1:0][REG_IDX_W-1:0] vrf_wr_index;
  logic [NUM_RT_UOP-1:0][VLEN-1:0]      vrf_wr_data;
  logic [NUM_RT_UOP-1:0][VLENB-1:0]     vrf_wr_strobe;

  rvv_rob #(.NUM_RT_UOP(NUM_RT_UOP), .ROB_DEPTH(ROB_DEPTH)) u_rob (
    .clk, .rst_n, .push_valid, .push_entry, .push_ready, .rt(rob_rt.rob)
  );

  rvv_retire #(.NUM_RT_UOP(NUM_RT_UOP)) u_retire (
    .rob(rob_rt.rt), .xrf(xrf_req.rt),
    .vrf_wr_valid, .vrf_wr_index, .vrf_wr_data, .vrf_wr_strobe,
    .trap_valid, .trap_vcsr, .vxsat_valid, .vxsat
  );

  rvv_vrf #(.NUM_RT_UOP(NUM_RT_UOP)) u_vrf (
    .clk, .rst_n,
    .wr_valid(vrf_wr_valid), .wr_index(vrf_wr_index),
    .wr_data(vrf_wr_data), .wr_strobe(vrf_wr_strobe),
    .rd_index(vrf_rd_index), .rd_data(vrf_rd_data)
  );

  rvv_xrf_arbiter #(.NUM_RT_UOP(NUM_RT_UOP)) u_xrf_arb (
    .clk, .rst_n, .req(xrf_req.arb), .wb(xrf_wb.master)
  );

  rvv_xrf u_xrf (
    .clk, .rst_n, .wb(xrf_wb.slave), .rd_index(xrf_rd_index), .rd_data(xrf_rd_data)
  );

endmodule

//--- tb_clk_gen.sv
// testbench clock and power-on reset for the retire stage
module tb_clk_gen #(
  parameter int HALF_NS    = 10,   // 20 ns period
  parameter int RST_CYCLES = 3
) (
  output logic clk,
  output logic rst_n
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever #HALF_NS clk = ~clk;
  end

  initial begin
    rst_n = 1'b1;
    #2 rst_n = 1'b0;                    // real falling edge for the async reset
    repeat (RST_CYCLES) @(posedge clk);
    #2 rst_n = 1'b1;
  end

endmodule

//--- tb_rvv_backend.sv
// testbench for the retire stage, shadow register files and assertion checks
module tb_rvv_backend;
  timeunit 1ns;
  timeprecision 100ps;
  import rvv_pkg::*;

  localparam int MAX_CYCLES = 2000;
  localparam int STALL_MAX  = 40;   // longest push_ready low stretch tolerated

  logic                 clk;
  logic                 rst_n;
  logic                 push_valid;
  rob_entry_t           push_entry;
  logic                 push_ready;
  logic [REG_IDX_W-1:0] vrf_rd_index;
  logic [VLEN-1:0]      vrf_rd_data;
  logic [REG_IDX_W-1:0] xrf_rd_index;
  logic [XLEN-1:0]      xrf_rd_data;
  logic                 trap_valid;
  vector_csr_t          trap_vcsr;
  logic                 vxsat_valid;
  logic                 vxsat;

  logic [VLEN-1:0] vrf_model [32];   // shadow files, updated in program order
  logic [XLEN-1:0] xrf_model [32];
  logic [31:0]     seed = 32'h87fb;
  vector_csr_t     exp_vcsr;
  logic            exp_vx;
  logic            vx_chk;
  logic            trap_seen;
  logic            full_seen;
  int              stall_cnt = 0;
  int              cycles = 0;
  int              val_errs = 0;
  int              other_errs = 0;

  tb_clk_gen u_clk_gen (.clk, .rst_n);

  rvv_backend_top #(.NUM_RT_UOP(4), .ROB_DEPTH(8)) u_dut (
    .clk, .rst_n, .push_valid, .push_entry, .push_ready,
    .vrf_rd_index, .vrf_rd_data, .xrf_rd_index, .xrf_rd_data,
    .trap_valid, .trap_vcsr, .vxsat_valid, .vxsat
  );

  ////////////////////
  // monitors
  ////////////////////
  always @(posedge clk) begin
    exp_vx <= push_valid && push_entry.vxsat;   // single vrf uop is offered next cycle
  end

  always @(negedge clk) begin
    if (trap_valid) trap_seen <= 1'b1;
    stall_cnt <= push_ready ? 0 : stall_cnt + 1;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == MAX_CYCLES) begin
      $display("timeout, run did not finish within %0d cycles", MAX_CYCLES);
      $display("errors: %0d wrong values, %0d other failures", val_errs, other_errs);
      $display("Checks failed");
      $finish;
    end
  end

  a_reset_quiet: assert property (@(posedge clk)
    !rst_n |-> !trap_valid && !vxsat_valid && push_ready)
    else begin
      other_errs++;
      $display("outputs not idle during reset at %0t", $time);
    end

  a_trap_vcsr: assert property (@(posedge clk) disable iff (!rst_n)
    trap_valid |-> trap_vcsr == exp_vcsr)
    else begin
      val_errs++;
      $display("error %0t trap_vcsr expected %h actual %h",
               $time, $sampled(exp_vcsr), $sampled(trap_vcsr));
    end

  a_vxsat: assert property (@(posedge clk) disable iff (!rst_n)
    vx_chk |-> vxsat_valid == exp_vx)
    else begin
      val_errs++;
      $display("error %0t vxsat_valid expected %b actual %b",
               $time, $sampled(exp_vx), $sampled(vxsat_valid));
    end

  a_vxsat_val: assert property (@(posedge clk) disable iff (!rst_n)
    vx_chk |-> vxsat == exp_vx)
    else begin
      val_errs++;
      $display("error %0t vxsat expected %b actual %b",
               $time, $sampled(exp_vx), $sampled(vxsat));
    end

  a_wb_hold: assert property (@(posedge clk) disable iff (!rst_n)
    u_dut.xrf_wb.cyc && !u_dut.xrf_wb.ack |=> u_dut.xrf_wb.cyc && u_dut.xrf_wb.stb)
    else begin
      other_errs++;
      $display("wishbone cycle dropped before ack at %0t", $time);
    end

  a_push_drains: assert property (@(posedge clk) disable iff (!rst_n)
    stall_cnt < STALL_MAX)
    else begin
      other_errs++;
      $display("push_ready stuck low, rob does not drain, at %0t", $time);
    end

  ////////////////////
  // helpers
  ////////////////////
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] rnd();
    seed = xorshift32(seed);
    return seed;
  endfunction

  function automatic rob_entry_t make_uop(input logic is_xrf, input logic [REG_IDX_W-1:0] idx);
    rob_entry_t  e;
    logic [31:0] r;
    e             = '0;
    r             = rnd();
    e.w_valid     = 1'b1;
    e.w_type      = is_xrf;
    e.w_index     = idx;
    e.w_data.vec  = {rnd(), rnd()};
    e.vd_strobe   = r[VLENB-1:0];
    return e;
  endfunction

  // program-order effect of one uop on the shadow files
  task automatic apply_model(input rob_entry_t e);
    logic [VLENB-1:0] strb;
    strb = (e.ignore_vta && e.ignore_vma) ? '1 : e.vd_strobe;
    if (e.w_valid && e.w_type) begin
      xrf_model[e.w_index] = e.w_data.vec[XLEN-1:0];
    end else if (e.w_valid) begin
      for (int b = 0; b < VLENB; b++) begin
        if (strb[b]) vrf_model[e.w_index][b*8 +: 8] = e.w_data.vec[b*8 +: 8];
      end
    end
  endtask

  task automatic push_uop(input rob_entry_t e, input logic squashed);
    if (!squashed) apply_model(e);
    push_valid = 1'b1;
    push_entry = e;
    @(negedge clk);
    while (!push_ready) begin
      full_seen = 1'b1;
      @(negedge clk);
    end
    @(posedge clk);
    #2;
    push_valid = 1'b0;
  endtask

  // wait until the rob is empty and the bus idle
  task automatic drain();
    while (u_dut.rob_rt.valid[0] || u_dut.xrf_wb.cyc) begin
      @(posedge clk);
      #2;
    end
  endtask

  task automatic check_regs();
    for (int r = 0; r < 32; r++) begin
      vrf_rd_index = REG_IDX_W'(r);
      xrf_rd_index = REG_IDX_W'(r);
      @(negedge clk);
      assert (vrf_rd_data === vrf_model[r]) else begin
        val_errs++;
        $display("error %0t vrf_rd_data[%0d] expected %h actual %h",
                 $time, r, vrf_model[r], vrf_rd_data);
      end
      assert (xrf_rd_data === xrf_model[r]) else begin
        val_errs++;
        $display("error %0t xrf_rd_data[%0d] expected %h actual %h",
                 $time, r, xrf_model[r], xrf_rd_data);
      end
      @(posedge clk);
      #2;
    end
  endtask

  ////////////////////
  // stimulus
  ////////////////////
  initial begin
    rob_entry_t  e;
    logic [31:0] r;
    push_valid   = 1'b0;
    push_entry   = '0;
    vrf_rd_index = '0;
    xrf_rd_index = '0;
    exp_vcsr     = '0;
    vx_chk       = 1'b0;
    trap_seen    = 1'b0;
    full_seen    = 1'b0;
    for (int i = 0; i < 32; i++) begin
      vrf_model[i] = '0;
      xrf_model[i] = '0;
    end
    wait (!rst_n);
    wait (rst_n);
    @(negedge clk);
    assert (push_ready && !trap_valid && !vxsat_valid) else begin
      other_errs++;
      $display("outputs not idle right after reset at %0t", $time);
    end
    @(posedge clk);
    #2;
    check_regs();   // both files cleared by reset

    // independent vrf writes, every third uop fully agnostic
    for (int i = 0; i < 16; i++) begin
      e = make_uop(1'b0, REG_IDX_W'(i));
      e.ignore_vta = (i % 3 != 2);
      e.ignore_vma = (i % 3 == 0);
      push_uop(e, 1'b0);
    end
    drain();
    check_regs();

    // waw bursts held together behind two xrf uops
    for (int b = 0; b < 3; b++) begin
      push_uop(make_uop(1'b1, REG_IDX_W'(8 + 2*b)), 1'b0);
      push_uop(make_uop(1'b1, REG_IDX_W'(9 + 2*b)), 1'b0);
      for (int k = 0; k < 4; k++) begin
        e = make_uop(1'b0, (b == 0) ? REG_IDX_W'(16) : REG_IDX_W'(15 + 2*b + (k % 2)));
        e.vd_strobe = e.vd_strobe | 8'h18;   // force overlap
        push_uop(e, 1'b0);
      end
    end
    drain();
    check_regs();

    ////////////////////
    // xrf mix and back-pressure
    ////////////////////
    full_seen = 1'b0;
    for (int i = 0; i < 24; i++) begin
      r = rnd();
      push_uop(make_uop(i < 12 || r[0], r[5:1]), 1'b0);
    end
    drain();
    assert (full_seen) else begin
      other_errs++;
      $display("push_ready never dropped, back-pressure not reached");
    end
    check_regs();

    // trap in the middle of a stalled group, last uop squashed
    push_uop(make_uop(1'b1, REG_IDX_W'(5)), 1'b0);
    push_uop(make_uop(1'b1, REG_IDX_W'(6)), 1'b0);
    push_uop(make_uop(1'b0, REG_IDX_W'(24)), 1'b0);
    e = make_uop(1'b0, REG_IDX_W'(25));
    r = rnd();
    e.trap_flag  = 1'b1;
    e.vector_csr = r[15:0];
    exp_vcsr     = e.vector_csr;
    push_uop(e, 1'b0);
    push_uop(make_uop(1'b0, REG_IDX_W'(26)), 1'b1);
    drain();
    assert (trap_seen) else begin
      other_errs++;
      $display("trap_valid never rose for the trapping uop");
    end
    check_regs();

    // vxsat on single vrf uops
    vx_chk = 1'b1;
    for (int i = 0; i < 16; i++) begin
      r = rnd();
      e = make_uop(1'b0, r[5:1]);
      e.vxsat = r[6];
      push_uop(e, 1'b0);
    end
    drain();
    vx_chk = 1'b0;
    check_regs();

    $display("errors: %0d wrong values, %0d other failures", val_errs, other_errs);
    if (val_errs == 0 && other_errs == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- all.f
rvv_pkg.sv
rvv_ifs.sv
rvv_rob.sv
rvv_retire.sv
rvv_vrf.sv
rvv_xrf_arbiter.sv
rvv_xrf.sv
rvv_backend_top.sv
tb_clk_gen.sv
tb_rvv_backend.sv

//--- run.sh
#!/bin/sh
# build and run the retire stage testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_rvv_backend
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vtb_rvv_backend > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Checks failed" sim.log; then
  exit 1
fi
exit 0
